// File: all.f
hdl/rv_pkg.sv
hdl/rv_alu.sv
hdl/rv_regfile.sv
hdl/rv_decode.sv
hdl/rv_control.sv
hdl/rv_core.sv
tb/rv_core_properties.sv
tb/tb_rv_core.sv

// File: tb/tb_rv_core.sv
module tb_rv_core;
	import rv_pkg::*;

	logic        clk = 1'b0;
	logic        rst;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	logic        halted;
	logic [31:0] mem [0:255];
	logic [31:0] exp_data [0:63];            // store area at 0x300
	logic        exp_valid [0:63];
	logic        seen [0:63];
	int          wait_tab [0:1023];
	int          wait_left = 0;
	int          req_n = 0;
	int          cycles = 0;
	int          ecall_cycle = -1;
	int          pc_w = 0;
	int          slot = 0;
	int          prog_len = 0;
	int          value_errors = 0;
	int          flow_errors = 0;

	rv_core dut0 (
		.clk    (clk),
		.rst    (rst),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp),
		.halted (halted)
	);

	initial
	begin
		forever #5 clk = ~clk;
	end

	// ------------------------------
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
	endfunction

	function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
		input int f3, input int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
		input int rd, input int opc);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
	endfunction

	function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
		input int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] u_type(input int imm, input int rd, input int opc);
		return {imm[19:0], rd[4:0], opc[6:0]};
	endfunction

	function automatic logic [31:0] j_type(input int imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	task automatic emit(input logic [31:0] word);
		mem[pc_w] = word;
		pc_w++;
	endtask

	task automatic expect_store(input int rs, input logic [31:0] value);
		emit(s_type(slot * 4, rs, 31));
		exp_data[slot]  = value;
		exp_valid[slot] = 1'b1;
		slot++;
	endtask

	task automatic poison_store();
		emit(s_type(slot * 4, 6, 31));       // slot stays invalid
		slot++;
	endtask

	task automatic reg_op(input int f7, input int f3, input int rs1, input int rs2,
		input logic [31:0] value);
		emit(r_type(f7, rs2, rs1, f3, 10));
		expect_store(10, value);
	endtask

	task automatic imm_op(input int f3, input int rs1, input int imm, input logic [31:0] value);
		emit(i_type(imm, rs1, f3, 10, 'h13));
		expect_store(10, value);
	endtask

	task automatic branch_case(input int f3, input int rs1, input int rs2, input logic taken);
		emit(b_type(8, rs2, rs1, f3));       // skips the marker when taken
		if (taken)
			poison_store();
		else
			expect_store(6, 32'h0000_005a);
	endtask

	task automatic load_program();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] sh;
		int          p;
		a  = 32'hffff_fff9;
		b  = 32'd13;
		c  = 32'h1234_5678;
		sh = 32'd35;
		for (int i = 0; i < 256; i++)
			mem[i] = fill_word(32'(i * 4));
		for (int i = 0; i < 64; i++)
		begin
			exp_valid[i] = 1'b0;
			seen[i]      = 1'b0;
		end
		emit(i_type(768, 0, 0, 31, 'h13));  // store base
		emit(i_type(-7, 0, 0, 1, 'h13));
		emit(i_type(13, 0, 0, 2, 'h13));
		emit(u_type('h12345, 3, 'h37));
		emit(i_type('h678, 3, 0, 3, 'h13));
		emit(i_type(35, 0, 0, 4, 'h13));     // shift uses low five bits only
		emit(i_type('h5a, 0, 0, 6, 'h13));   // branch marker
		reg_op(0, 0, 1, 2, a + b);
		reg_op(32, 0, 1, 2, a - b);
		reg_op(0, 7, 1, 3, a & c);
		reg_op(0, 6, 1, 3, a | c);
		reg_op(0, 4, 1, 3, a ^ c);
		reg_op(0, 1, 3, 4, c << sh[4:0]);
		reg_op(0, 5, 1, 4, a >> sh[4:0]);
		reg_op(32, 5, 1, 4, {{3{a[31]}}, a[31:3]});
		reg_op(0, 2, 1, 2, {31'd0, $signed(a) < $signed(b)});
		reg_op(0, 2, 2, 1, {31'd0, $signed(b) < $signed(a)});
		reg_op(0, 3, 1, 2, {31'd0, a < b});
		reg_op(0, 3, 2, 1, {31'd0, b < a});
		imm_op(0, 1, -100, a - 32'd100);
		imm_op(7, 3, 'h0f0, c & 32'h0000_00f0);
		imm_op(6, 2, -256, b | 32'hffff_ff00);
		imm_op(4, 3, -1, ~c);
		imm_op(2, 1, -8, {31'd0, $signed(a) < -32'sd8});
		imm_op(2, 1, 5, {31'd0, $signed(a) < 32'sd5});
		imm_op(3, 2, -1, {31'd0, b < 32'hffff_ffff});
		imm_op(3, 1, 20, {31'd0, a < 32'd20});
		imm_op(1, 3, 4, c << 4);
		imm_op(5, 1, 28, a >> 28);
		imm_op(5, 1, 'h402, {{2{a[31]}}, a[31:2]});
		// ------------------------------
		emit(u_type('habcde, 13, 'h37));
		expect_store(13, 32'habcd_e000);
		p = pc_w * 4;
		emit(u_type('h10, 14, 'h17));
		expect_store(14, 32'(p) + 32'h0001_0000);
		emit(i_type('h200, 0, 2, 11, 'h03));
		expect_store(11, fill_word(32'h0000_0200));
		emit(i_type(-252, 31, 2, 12, 'h03)); // negative offset from the base
		expect_store(12, fill_word(32'h0000_0204));
		p = pc_w * 4;
		emit(j_type(8, 15));
		poison_store();
		expect_store(15, 32'(p + 4));
		p = pc_w * 4;
		emit(u_type(0, 5, 'h17));
		emit(i_type(13, 5, 0, 16, 'h67));    // odd target, bit 0 dropped
		poison_store();
		expect_store(16, 32'(p + 8));
		// ------------------------------
		branch_case(0, 2, 2, b == b);
		branch_case(0, 1, 2, a == b);
		branch_case(1, 1, 2, a != b);
		branch_case(1, 2, 2, b != b);
		branch_case(4, 1, 2, $signed(a) < $signed(b));
		branch_case(4, 2, 1, $signed(b) < $signed(a));
		branch_case(5, 2, 1, $signed(b) >= $signed(a));
		branch_case(5, 1, 2, $signed(a) >= $signed(b));
		branch_case(6, 2, 1, b < a);
		branch_case(6, 1, 2, a < b);
		branch_case(7, 1, 2, a >= b);
		branch_case(7, 2, 1, b >= a);
		emit(32'h0000_0073);                 // ecall
		prog_len = pc_w;
	endtask

	task automatic check_store(input logic [31:0] adr, input logic [31:0] dat);
		int   idx;
		logic ok;
		idx = int'(adr[7:2]);
		ok  = (adr[31:8] == 24'h00_0003) && exp_valid[idx] && !seen[idx];
		assert (ok)
		else
		begin
			flow_errors++;
			$display("Unexpected store of %h to address %h at time %0t", dat, adr, $time);
		end
		if (ok)
		begin
			seen[idx] = 1'b1;
			assert (dat == exp_data[idx])
			else
			begin
				value_errors++;
				$display("Error at time %0t: wb_req.dat expected %h, got %h",
					$time, exp_data[idx], dat);
			end
		end
	endtask

	task automatic print_counts();
		$display("Summary: %0d store value errors, %0d control flow errors, %0d assertion failures",
			value_errors, flow_errors, dut0.props0.fail_count);
	endtask

	// ------------------------------
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (wb_rsp.ack)
			wb_rsp.ack <= 1'b0;
		else if (wb_req.cyc && wb_req.stb)
		begin
			if (wait_left > 0)
				wait_left <= wait_left - 1;
			else
			begin
				wb_rsp.ack <= 1'b1;
				wait_left  <= wait_tab[req_n % 1024];
				req_n      <= req_n + 1;
				if (wb_req.we)
					check_store(wb_req.adr, wb_req.dat);
				else
				begin
					wb_rsp.dat <= mem[wb_req.adr[9:2]];
					if (mem[wb_req.adr[9:2]] == 32'h0000_0073)
						ecall_cycle <= cycles;
				end
			end
		end
	end

	initial
	begin
		wait (prog_len > 0);
		repeat (prog_len * 4 * 8 + 200) @(posedge clk);
		$display("Timeout: the core did not halt in time");
		print_counts();
		$display("Checks failed");
		$finish;
	end

	initial
	begin
		rst    <= 1'b0;
		wb_rsp <= '0;
		void'($urandom(32'hbdf7_91aa));
		for (int i = 0; i < 1024; i++)
			wait_tab[i] = int'($urandom % 4);
		load_program();
		repeat (16) @(posedge clk);
		rst <= 1'b1;
		@(posedge clk);
		while (!halted)
			@(posedge clk);
		assert (ecall_cycle >= 0 && cycles - ecall_cycle <= 4)
		else
		begin
			flow_errors++;
			$display("halted did not rise within 4 cycles of the final ECALL fetch");
		end
		repeat (20) @(posedge clk);
		for (int i = 0; i < slot; i++)
		begin
			assert (!exp_valid[i] || seen[i])
			else
			begin
				flow_errors++;
				$display("Store to address %h never happened", 32'(32'h300 + 4 * i));
			end
		end
		print_counts();
		if (value_errors + flow_errors + dut0.props0.fail_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: tb/rv_core_properties.sv
module rv_core_properties (
	input logic            clk,
	input logic            rst,
	input rv_pkg::wb_req_t wb_req,
	input rv_pkg::wb_rsp_t wb_rsp,
	input logic            halted,
	input rv_pkg::state_t  state,
	input logic            legal
);
	import rv_pkg::*;

	int fail_count = 0;

	// ------------------------------
	reset_idle: assert property (@(posedge clk) !rst |-> !wb_req.cyc && !wb_req.stb && !halted)
	else
	begin
		$error("bus request or halted active during reset");
		fail_count++;
	end

	first_fetch: assert property (@(posedge clk)
		$rose(rst) |-> !wb_req.cyc ##1 (wb_req.cyc && wb_req.adr == reset_pc))
	else
	begin
		$error("first fetch did not start at the reset address");
		fail_count++;
	end

	// ------------------------------
	stb_needs_cyc: assert property (@(posedge clk) disable iff (!rst) wb_req.stb |-> wb_req.cyc)
	else
	begin
		$error("stb high without cyc");
		fail_count++;
	end

	request_held: assert property (@(posedge clk) disable iff (!rst)
		wb_req.stb && !wb_rsp.ack |=> wb_req.stb && $stable(wb_req.we) &&
		$stable(wb_req.adr) && $stable(wb_req.dat))
	else
	begin
		$error("request changed before ack");
		fail_count++;
	end

	fetch_is_read: assert property (@(posedge clk) disable iff (!rst)
		state == st_fetch && wb_req.stb |-> !wb_req.we)
	else
	begin
		$error("write request during an instruction fetch");
		fail_count++;
	end

	// ------------------------------
	illegal_halts: assert property (@(posedge clk) disable iff (!rst)
		state == st_decode && !legal |=> halted)
	else
	begin
		$error("illegal or system opcode did not halt the core");
		fail_count++;
	end

	halt_final: assert property (@(posedge clk) disable iff (!rst)
		halted |=> halted && !wb_req.cyc)
	else
	begin
		$error("core left halt or started a bus cycle after halting");
		fail_count++;
	end

endmodule

bind rv_core rv_core_properties props0 (
	.clk    (clk),
	.rst    (rst),
	.wb_req (wb_req),
	.wb_rsp (wb_rsp),
	.halted (halted),
	.state  (control0.state),
	.legal  (dec.legal)
);

// File: hdl/rv_core.sv
module rv_core (
	input  logic            clk,
	input  logic            rst,
	output rv_pkg::wb_req_t wb_req,
	input  rv_pkg::wb_rsp_t wb_rsp,
	output logic            halted
);
	import rv_pkg::*;

	decode_t               dec;
	alu_status_t           status;
	logic                  branch_taken;
	logic [xlen-1:0]       instr;
	logic [xlen-1:0]       alu_a;
	logic [xlen-1:0]       alu_b;
	logic [xlen-1:0]       alu_result;
	logic [xlen-1:0]       rs1_data;
	logic [xlen-1:0]       rs2_data;
	logic                  rd_we;
	logic [reg_addr_w-1:0] rd_addr;
	logic [xlen-1:0]       rd_data;

	rv_control control0 (
		.clk          (clk),
		.rst          (rst),
		.dec          (dec),
		.branch_taken (branch_taken),
		.alu_result   (alu_result),
		.rs1_data     (rs1_data),
		.rs2_data     (rs2_data),
		.wb_rsp       (wb_rsp),
		.instr        (instr),
		.alu_a        (alu_a),
		.alu_b        (alu_b),
		.rd_we        (rd_we),
		.rd_addr      (rd_addr),
		.rd_data      (rd_data),
		.wb_req       (wb_req),
		.halted       (halted)
	);

	rv_decode decode0 (
		.instr        (instr),
		.status       (status),
		.dec          (dec),
		.branch_taken (branch_taken)
	);

	rv_alu alu0 (
		.a      (alu_a),
		.b      (alu_b),
		.op     (dec.alu_op),
		.result (alu_result),
		.status (status)
	);

	rv_regfile regfile0 (
		.clk      (clk),
		.rst      (rst),
		.rs1_addr (dec.rs1),
		.rs2_addr (dec.rs2),
		.rd_addr  (rd_addr),
		.rd_we    (rd_we),
		.rd_data  (rd_data),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

endmodule

// File: hdl/rv_control.sv
module rv_control (
	input  logic                          clk,
	input  logic                          rst,
	input  rv_pkg::decode_t               dec,
	input  logic                          branch_taken,
	input  logic [rv_pkg::xlen-1:0]       alu_result,
	input  logic [rv_pkg::xlen-1:0]       rs1_data,
	input  logic [rv_pkg::xlen-1:0]       rs2_data,
	input  rv_pkg::wb_rsp_t               wb_rsp,
	output logic [rv_pkg::xlen-1:0]       instr,
	output logic [rv_pkg::xlen-1:0]       alu_a,
	output logic [rv_pkg::xlen-1:0]       alu_b,
	output logic                          rd_we,
	output logic [rv_pkg::reg_addr_w-1:0] rd_addr,
	output logic [rv_pkg::xlen-1:0]       rd_data,
	output rv_pkg::wb_req_t               wb_req,
	output logic                          halted
);
	import rv_pkg::*;

	state_t          state;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] pc_plus4;
	logic [xlen-1:0] target;
	logic [xlen-1:0] pc_next;
	logic [xlen-1:0] ir;
	logic [xlen-1:0] alu_q;
	logic [xlen-1:0] load_q;
	logic            writes_rd;
	logic            is_mem;

	assign pc_plus4  = pc + 32'd4;
	assign target    = pc + dec.imm;                 // jal and branch
	assign writes_rd = dec.opcode inside {opc_lui, opc_auipc, opc_jal, opc_jalr,
		opc_op, opc_op_imm, opc_load};
	assign is_mem    = dec.opcode inside {opc_load, opc_store};

	always_comb
	begin
		case (dec.opcode)
			opc_jal:    pc_next = target;
			opc_jalr:   pc_next = {alu_q[xlen-1:1], 1'b0};
			opc_branch: pc_next = branch_taken ? target : pc_plus4;
			default:    pc_next = pc_plus4;
		endcase
	end

	// ------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state  <= st_fetch;
			pc     <= reset_pc;
			wb_req <= '0;
		end
		else
		begin
			case (state)
				st_fetch:
				begin
					if (!wb_req.cyc)                     // first fetch after reset
					begin
						wb_req.cyc <= 1'b1;
						wb_req.stb <= 1'b1;
						wb_req.we  <= 1'b0;
						wb_req.adr <= pc;
					end
					else if (wb_rsp.ack)
					begin
						wb_req.cyc <= 1'b0;
						wb_req.stb <= 1'b0;
						state      <= st_decode;
					end
				end
				st_decode: state <= dec.legal ? st_execute : st_halt;
				st_execute:
				begin
					if (is_mem)
					begin
						wb_req.cyc <= 1'b1;
						wb_req.stb <= 1'b1;
						wb_req.we  <= (dec.opcode == opc_store);
						wb_req.adr <= alu_result;
						wb_req.dat <= rs2_data;
						state      <= st_mem;
					end
					else
						state <= st_writeback;
				end
				st_mem:
				begin
					if (wb_rsp.ack)
					begin
						wb_req.cyc <= 1'b0;
						wb_req.stb <= 1'b0;
						wb_req.we  <= 1'b0;
						state      <= st_writeback;
					end
				end
				st_writeback: state <= st_pc_update;
				st_pc_update:
				begin
					pc         <= pc_next;
					wb_req.cyc <= 1'b1;                // next fetch starts here
					wb_req.stb <= 1'b1;
					wb_req.we  <= 1'b0;
					wb_req.adr <= pc_next;
					state      <= st_fetch;
				end
				default: state <= st_halt;         // halt is terminal
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == st_fetch && wb_req.cyc && wb_rsp.ack)
			ir <= wb_rsp.dat;
		if (state == st_execute)
			alu_q <= alu_result;
		if (state == st_mem && wb_rsp.ack)
			load_q <= wb_rsp.dat;
	end

	// ------------------------------
	always_comb
	begin
		case (dec.opcode)
			opc_lui:  rd_data = dec.imm;
			opc_jal:  rd_data = pc_plus4;
			opc_jalr: rd_data = pc_plus4;
			opc_load: rd_data = load_q;
			default:  rd_data = alu_q;
		endcase
	end

	assign instr   = ir;
	assign alu_a   = (dec.opcode == opc_auipc) ? pc : rs1_data;
	assign alu_b   = dec.b_imm ? dec.imm : rs2_data;
	assign rd_we   = (state == st_writeback) && writes_rd;
	assign rd_addr = dec.rd;
	assign halted  = (state == st_halt);

endmodule

// File: hdl/rv_decode.sv
module rv_decode (
	input  logic [rv_pkg::xlen-1:0] instr,
	input  rv_pkg::alu_status_t     status,
	output rv_pkg::decode_t         dec,
	output logic                    branch_taken
);
	import rv_pkg::*;

	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_s;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm_u;
	logic [xlen-1:0] imm_j;
	logic            cond;

	function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: alu_sel = alt ? alu_sub : alu_add;
			3'b001: alu_sel = alu_sll;
			3'b010: alu_sel = alu_slt;
			3'b011: alu_sel = alu_sltu;
			3'b100: alu_sel = alu_xor;
			3'b101: alu_sel = alt ? alu_sra : alu_srl;
			3'b110: alu_sel = alu_or;
			default: alu_sel = alu_and;
		endcase
	endfunction

	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign imm_i  = {{20{instr[31]}}, instr[31:20]};
	assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u  = {instr[31:12], 12'd0};
	assign imm_j  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb
	begin
		dec.opcode = opcode_t'(instr[6:0]);
		dec.rd     = instr[11:7];
		dec.rs1    = instr[19:15];
		dec.rs2    = instr[24:20];
		dec.imm    = imm_i;
		dec.alu_op = alu_add;
		dec.b_imm  = 1'b1;
		dec.legal  = 1'b1;
		case (dec.opcode)
			opc_lui, opc_auipc: dec.imm = imm_u;
			opc_jal:   dec.imm = imm_j;
			opc_jalr:  dec.legal = (funct3 == 3'b000);
			opc_branch:
			begin
				dec.imm   = imm_b;
				dec.b_imm = 1'b0;                    // compare rs1 with rs2
				dec.legal = (funct3[2:1] != 2'b01);
			end
			opc_load:  dec.legal = (funct3 == 3'b010);   // word only
			opc_store:
			begin
				dec.imm   = imm_s;
				dec.legal = (funct3 == 3'b010);
			end
			opc_op_imm:
			begin
				dec.alu_op = alu_sel(funct3, funct3 == 3'b101 && instr[30]);
				if (funct3 == 3'b001)
					dec.legal = (funct7 == 7'b0000000);
				else if (funct3 == 3'b101)
					dec.legal = ((funct7 & 7'b1011111) == 7'b0000000);
			end
			opc_op:
			begin
				dec.b_imm  = 1'b0;
				dec.alu_op = alu_sel(funct3, instr[30]);
				dec.legal  = (funct7 == 7'b0000000) ||
					(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
			end
			opc_system: dec.legal = 1'b0;      // ecall, ebreak and csr all stop
			default:    dec.legal = 1'b0;
		endcase
	end

	always_comb
	begin
		case (funct3)
			3'b000:  cond = status.eq;
			3'b001:  cond = !status.eq;
			3'b100:  cond = status.lt;
			3'b101:  cond = !status.lt;
			3'b110:  cond = status.ltu;
			3'b111:  cond = !status.ltu;
			default: cond = 1'b0;
		endcase
	end

	assign branch_taken = (dec.opcode == opc_branch) && cond;

endmodule

// File: hdl/rv_regfile.sv
module rv_regfile (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
	input  logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
	input  logic [rv_pkg::reg_addr_w-1:0] rd_addr,
	input  logic                          rd_we,
	input  logic [rv_pkg::xlen-1:0]       rd_data,
	output logic [rv_pkg::xlen-1:0]       rs1_data,
	output logic [rv_pkg::xlen-1:0]       rs2_data
);
	import rv_pkg::*;

	logic [xlen-1:0] regs [1:reg_count-1];   // no storage for x0

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			for (int i = 1; i < reg_count; i++)
				regs[i] <= '0;
		end
		else if (rd_we && rd_addr != '0)
			regs[rd_addr] <= rd_data;
	end

	assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: hdl/rv_alu.sv
module rv_alu (
	input  logic [rv_pkg::xlen-1:0] a,
	input  logic [rv_pkg::xlen-1:0] b,
	input  rv_pkg::alu_op_t         op,
	output logic [rv_pkg::xlen-1:0] result,
	output rv_pkg::alu_status_t     status
);
	import rv_pkg::*;

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb
	begin
		case (op)
			alu_add:  result = a + b;
			alu_sub:  result = a - b;
			alu_and:  result = a & b;
			alu_or:   result = a | b;
			alu_xor:  result = a ^ b;
			alu_sll:  result = a << shamt;
			alu_srl:  result = a >> shamt;
			alu_sra:  result = $signed(a) >>> shamt;
			alu_slt:  result = {{(xlen-1){1'b0}}, status.lt};
			alu_sltu: result = {{(xlen-1){1'b0}}, status.ltu};
			default:  result = '0;
		endcase
	end

	// flags for branches, independent of op
	assign status.eq  = (a == b);
	assign status.lt  = ($signed(a) < $signed(b));
	assign status.ltu = (a < b);

endmodule

// File: hdl/rv_pkg.sv
package rv_pkg;

	// ------------------------------
	localparam int xlen       = 32;
	localparam int reg_addr_w = 5;
	localparam int reg_count  = 32;

	localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

	// ------------------------------
	typedef enum logic [6:0] {
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_op_imm = 7'b0010011,
		opc_op     = 7'b0110011,
		opc_system = 7'b1110011
	} opcode_t;

	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_sub  = 4'd1,
		alu_and  = 4'd2,
		alu_or   = 4'd3,
		alu_xor  = 4'd4,
		alu_sll  = 4'd5,
		alu_srl  = 4'd6,
		alu_sra  = 4'd7,
		alu_slt  = 4'd8,
		alu_sltu = 4'd9
	} alu_op_t;

	typedef struct packed {
		logic eq;
		logic lt;                            // signed
		logic ltu;
	} alu_status_t;

	typedef enum logic [4:0] {
		st_fetch,
		st_decode,
		st_execute,
		st_mem,
		st_writeback,
		st_pc_update,
		st_halt
	} state_t;

	// ------------------------------
	typedef struct packed {
		logic            cyc;
		logic            stb;
		logic            we;
		logic [xlen-1:0] adr;
		logic [xlen-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic            ack;
		logic [xlen-1:0] dat;
	} wb_rsp_t;

	typedef struct packed {
		opcode_t               opcode;
		logic [reg_addr_w-1:0] rd;
		logic [reg_addr_w-1:0] rs1;
		logic [reg_addr_w-1:0] rs2;
		logic [xlen-1:0]       imm;
		alu_op_t               alu_op;
		logic                  b_imm;        // alu b from immediate
		logic                  legal;
	} decode_t;

endpackage
